// File: Makefile
# Verilator build and run of the bus subsystem testbench

TOP = tb_bus_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timescale 1ns/1ps -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+design
design/bus_pkg.sv
design/bus_req_gate.sv
design/bus_split.sv
design/bus_ram_follower.sv
design/bus_reg_follower.sv
design/bus_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/tb_bus_subsys.sv

// File: design/bus_pkg.sv
`include "bus_settings.svh"

package bus_pkg;

   // Follower selection, also the index into the splitter follower vectors
   typedef enum logic [`BUS_FSEL_W-1:0] {
      FOL_RAM  = 'd0,
      FOL_REGS = 'd1
   } follower_t;

   // Word offsets inside the register bank
   // Offset 3 is unmapped and reads as zero
   typedef enum logic [1:0] {
      REG_SCRATCH = 2'd0,
      REG_ID      = 2'd1,
      REG_COUNT   = 2'd2
   } reg_offset_t;

   // Register bank wait-state controller
   typedef enum logic {
      RS_IDLE = 1'b0,
      RS_ACK  = 1'b1
   } reg_state_t;

endpackage

// File: design/bus_ram_follower.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_ram_follower (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   avalid_i,
   input  logic [`BUS_ADDR_W-1:0] address_i,
   input  logic [`BUS_DATA_W-1:0] wdata_i,
   input  logic [`BUS_STRB_W-1:0] wstrb_i,
   output logic [`BUS_DATA_W-1:0] rdata_o,
   output logic                   rvalid_o,
   output logic                   ready_o
);

   localparam int RAM_AW = $clog2(`BUS_RAM_WORDS);

   logic [`BUS_DATA_W-1:0] mem_q [0:`BUS_RAM_WORDS-1];
   logic [`BUS_DATA_W-1:0] rdata_q;
   logic                   rvalid_q;
   logic [RAM_AW-1:0]      word_idx;
   logic                   wr_accept;
   logic                   rd_accept;

   // Never stalls
   assign ready_o = 1'b1;

   // Word index from the byte address, upper bits alias
   assign word_idx = address_i[RAM_AW+1:2];

   assign wr_accept = avalid_i & ready_o & (|wstrb_i);
   assign rd_accept = avalid_i & ready_o & ~(|wstrb_i);

   // Array and read data register
   always_ff @(posedge clk_i) begin
      if (wr_accept) begin
         for (int b = 0; b < `BUS_STRB_W; b++) begin
            if (wstrb_i[b]) begin
               mem_q[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
      if (rd_accept) begin
         rdata_q <= mem_q[word_idx];
      end
   end

   // One cycle read latency
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_accept;
      end
   end

   assign rdata_o  = rdata_q;
   assign rvalid_o = rvalid_q;

endmodule

// File: design/bus_reg_follower.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_reg_follower (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   avalid_i,
   input  logic [`BUS_ADDR_W-1:0] address_i,
   input  logic [`BUS_DATA_W-1:0] wdata_i,
   input  logic [`BUS_STRB_W-1:0] wstrb_i,
   output logic [`BUS_DATA_W-1:0] rdata_o,
   output logic                   rvalid_o,
   output logic                   ready_o
);

   import bus_pkg::*;

   reg_state_t             state_q;
   reg_offset_t            offset;
   logic [`BUS_DATA_W-1:0] scratch_q;
   logic [`BUS_DATA_W-1:0] count_q;
   logic [`BUS_DATA_W-1:0] rd_mux;
   logic [`BUS_DATA_W-1:0] rdata_q;
   logic                   rvalid_q;
   logic                   wr_accept;
   logic                   rd_accept;

   // Word offset inside the bank, everything above aliases
   assign offset = reg_offset_t'(address_i[3:2]);

   // Accept only in the second cycle of a request
   assign ready_o   = (state_q == RS_ACK);
   assign wr_accept = avalid_i & ready_o & (|wstrb_i);
   assign rd_accept = avalid_i & ready_o & ~(|wstrb_i);

   // Wait-state controller
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= RS_IDLE;
      end else begin
         case (state_q)
            RS_IDLE: begin
               if (avalid_i) begin
                  state_q <= RS_ACK;
               end
            end
            default: begin
               state_q <= RS_IDLE;
            end
         endcase
      end
   end

   // Scratch register with byte strobes
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         scratch_q <= '0;
      end else if (wr_accept && offset == REG_SCRATCH) begin
         for (int b = 0; b < `BUS_STRB_W; b++) begin
            if (wstrb_i[b]) begin
               scratch_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
   end

   // Free-running cycle counter, not writable
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   // Read select
   always_comb begin
      case (offset)
         REG_SCRATCH: rd_mux = scratch_q;
         REG_ID:      rd_mux = `BUS_REG_ID_VAL;
         REG_COUNT:   rd_mux = count_q;
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         rdata_q <= rd_mux;
      end
   end

   // Response one cycle after acceptance
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_accept;
      end
   end

   assign rdata_o  = rdata_q;
   assign rvalid_o = rvalid_q;

endmodule

// File: design/bus_req_gate.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_req_gate (
   input  logic                  clk_i,
   input  logic                  arst_n_i,

   // Master request
   input  logic                  avalid_i,
   input  logic [`BUS_ADDR_W-1:0] address_i,
   input  logic [`BUS_STRB_W-1:0] wstrb_i,

   // Feedback from the splitter
   input  logic                  split_ready_i,
   input  logic                  split_rvalid_i,

   // Gated request towards the splitter
   output logic                  avalid_o,
   output logic                  ready_o,
   output bus_pkg::follower_t    fsel_o
);

   import bus_pkg::*;

   logic rd_pend_q;
   logic blocked;
   logic is_read;
   logic rd_accept;

   // Address decode, only the select bit matters so the map aliases
   always_comb begin
      if (address_i[`BUS_SEL_BIT]) begin
         fsel_o = FOL_REGS;
      end else begin
         fsel_o = FOL_RAM;
      end
   end

   // All strobes low means a read
   assign is_read = ~|wstrb_i;

   // Hold back new requests while a read response is owed
   // The returning rvalid releases the gate in the same cycle
   assign blocked = rd_pend_q & ~split_rvalid_i;

   assign avalid_o = avalid_i & ~blocked;
   assign ready_o  = split_ready_i & ~blocked;

   assign rd_accept = avalid_o & ready_o & is_read;

   // Outstanding read flag
   // A read accepted in the rvalid cycle keeps the flag set
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_pend_q <= 1'b0;
      end else if (rd_accept) begin
         rd_pend_q <= 1'b1;
      end else if (split_rvalid_i) begin
         rd_pend_q <= 1'b0;
      end
   end

endmodule

// File: design/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Native bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

// Followers behind the splitter
`define BUS_N_FOLWRS 2
`define BUS_FSEL_W 1

// RAM follower depth in 32-bit words
`define BUS_RAM_WORDS 256

// Address bit that picks the follower, 0 is RAM and 1 is the register bank
`define BUS_SEL_BIT 12

// Constant returned by the register bank identifier
`define BUS_REG_ID_VAL 32'hB05_5101

`endif

// File: design/bus_split.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_split #(
   parameter int N_FOLWRS = `BUS_N_FOLWRS
) (
   input  logic                           clk_i,
   input  logic                           arst_n_i,

   // Master side
   input  logic                           m_avalid_i,
   input  logic [`BUS_ADDR_W-1:0]         m_address_i,
   input  logic [`BUS_DATA_W-1:0]         m_wdata_i,
   input  logic [`BUS_STRB_W-1:0]         m_wstrb_i,
   input  bus_pkg::follower_t             fsel_i,
   output logic [`BUS_DATA_W-1:0]         m_rdata_o,
   output logic                           m_rvalid_o,
   output logic                           m_ready_o,

   // Follower side
   output logic [N_FOLWRS-1:0]            f_avalid_o,
   output logic [`BUS_ADDR_W-1:0]         f_address_o,
   output logic [`BUS_DATA_W-1:0]         f_wdata_o,
   output logic [`BUS_STRB_W-1:0]         f_wstrb_o,
   input  logic [N_FOLWRS*`BUS_DATA_W-1:0] f_rdata_i,
   input  logic [N_FOLWRS-1:0]            f_rvalid_i,
   input  logic [N_FOLWRS-1:0]            f_ready_i
);

   import bus_pkg::*;

   follower_t sel_q;

   // Request path steered by the live selection
   always_comb begin
      f_avalid_o = '0;
      m_ready_o  = 1'b0;
      for (int i = 0; i < N_FOLWRS; i++) begin
         if (i == int'(fsel_i)) begin
            f_avalid_o[i] = m_avalid_i;
            m_ready_o     = f_ready_i[i];
         end
      end
   end

   // Payload goes to every follower, only the selected one sees avalid
   assign f_address_o = m_address_i;
   assign f_wdata_o   = m_wdata_i;
   assign f_wstrb_o   = m_wstrb_i;

   // Remember who got the last accepted request
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= FOL_RAM;
      end else if (m_avalid_i && m_ready_o) begin
         sel_q <= fsel_i;
      end
   end

   // Response path steered by the registered selection
   always_comb begin
      m_rdata_o  = '0;
      m_rvalid_o = 1'b0;
      for (int i = 0; i < N_FOLWRS; i++) begin
         if (i == int'(sel_q)) begin
            m_rdata_o  = f_rdata_i[i*`BUS_DATA_W +: `BUS_DATA_W];
            m_rvalid_o = f_rvalid_i[i];
         end
      end
   end

endmodule

// File: design/bus_subsys_top.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_subsys_top (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   avalid_i,
   input  logic [`BUS_ADDR_W-1:0] address_i,
   input  logic [`BUS_DATA_W-1:0] wdata_i,
   input  logic [`BUS_STRB_W-1:0] wstrb_i,
   output logic [`BUS_DATA_W-1:0] rdata_o,
   output logic                   rvalid_o,
   output logic                   ready_o
);

   import bus_pkg::*;

   // Gate to splitter
   logic                                gate_avalid;
   follower_t                           gate_fsel;
   logic                                split_ready;

   // Splitter to followers
   logic [`BUS_N_FOLWRS-1:0]            f_avalid;
   logic [`BUS_ADDR_W-1:0]              f_address;
   logic [`BUS_DATA_W-1:0]              f_wdata;
   logic [`BUS_STRB_W-1:0]              f_wstrb;
   logic [`BUS_N_FOLWRS*`BUS_DATA_W-1:0] f_rdata;
   logic [`BUS_N_FOLWRS-1:0]            f_rvalid;
   logic [`BUS_N_FOLWRS-1:0]            f_ready;

   bus_req_gate u_req_gate (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .avalid_i      (avalid_i),
      .address_i     (address_i),
      .wstrb_i       (wstrb_i),
      .split_ready_i (split_ready),
      .split_rvalid_i(rvalid_o),
      .avalid_o      (gate_avalid),
      .ready_o       (ready_o),
      .fsel_o        (gate_fsel)
   );

   bus_split #(
      .N_FOLWRS(`BUS_N_FOLWRS)
   ) u_split (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .m_avalid_i (gate_avalid),
      .m_address_i(address_i),
      .m_wdata_i  (wdata_i),
      .m_wstrb_i  (wstrb_i),
      .fsel_i     (gate_fsel),
      .m_rdata_o  (rdata_o),
      .m_rvalid_o (rvalid_o),
      .m_ready_o  (split_ready),
      .f_avalid_o (f_avalid),
      .f_address_o(f_address),
      .f_wdata_o  (f_wdata),
      .f_wstrb_o  (f_wstrb),
      .f_rdata_i  (f_rdata),
      .f_rvalid_i (f_rvalid),
      .f_ready_i  (f_ready)
   );

   // Follower slots follow the follower_t encoding
   bus_ram_follower u_ram (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .avalid_i (f_avalid[FOL_RAM]),
      .address_i(f_address),
      .wdata_i  (f_wdata),
      .wstrb_i  (f_wstrb),
      .rdata_o  (f_rdata[FOL_RAM*`BUS_DATA_W +: `BUS_DATA_W]),
      .rvalid_o (f_rvalid[FOL_RAM]),
      .ready_o  (f_ready[FOL_RAM])
   );

   bus_reg_follower u_regs (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .avalid_i (f_avalid[FOL_REGS]),
      .address_i(f_address),
      .wdata_i  (f_wdata),
      .wstrb_i  (f_wstrb),
      .rdata_o  (f_rdata[FOL_REGS*`BUS_DATA_W +: `BUS_DATA_W]),
      .rvalid_o (f_rvalid[FOL_REGS]),
      .ready_o  (f_ready[FOL_REGS])
   );

endmodule

// File: testbench/tb_bus_subsys.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module tb_bus_subsys;

   import bus_pkg::*;

   localparam int          DRV_DELAY = 2;
   localparam int          TIMEOUT   = 50;
   localparam logic [31:0] REG_BASE  = 32'h1 << `BUS_SEL_BIT;

   logic                   clk;
   logic                   arst_n;
   logic                   avalid;
   logic [`BUS_ADDR_W-1:0] address;
   logic [`BUS_DATA_W-1:0] wdata;
   logic [`BUS_STRB_W-1:0] wstrb;
   logic [`BUS_DATA_W-1:0] rdata;
   logic                   rvalid;
   logic                   ready;

   // Model of the followers
   logic [`BUS_DATA_W-1:0] model_ram [0:`BUS_RAM_WORDS-1];
   logic [`BUS_DATA_W-1:0] model_scratch;

   // Expected responses in issue order
   // Counter reads are captured and not compared
   logic [`BUS_DATA_W-1:0] exp_q[$];
   bit                     capture_q[$];
   logic [`BUS_DATA_W-1:0] count_seen[$];
   logic [`BUS_DATA_W-1:0] mon_exp;

   int errors;
   int checks;
   bit timed_out;

   tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clock_gen (
      .clk_o   (clk),
      .arst_n_o(arst_n)
   );

   bus_subsys_top u_bus_subsys_top (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .avalid_i (avalid),
      .address_i(address),
      .wdata_i  (wdata),
      .wstrb_i  (wstrb),
      .rdata_o  (rdata),
      .rvalid_o (rvalid),
      .ready_o  (ready)
   );

   // Expected read value from the model
   // RAM word index is address bits 9..2
   function automatic logic [31:0] expected_read(input logic [31:0] addr);
      if (!addr[`BUS_SEL_BIT]) begin
         return model_ram[addr[9:2]];
      end
      case (reg_offset_t'(addr[3:2]))
         REG_SCRATCH: return model_scratch;
         REG_ID:      return `BUS_REG_ID_VAL;
         default:     return '0;
      endcase
   endfunction

   function automatic bit is_count(input logic [31:0] addr);
      return addr[`BUS_SEL_BIT] && (reg_offset_t'(addr[3:2]) == REG_COUNT);
   endfunction

   // Only strobed bytes change
   // ID and counter ignore writes
   function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b] && !addr[`BUS_SEL_BIT]) begin
            model_ram[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
         end else if (strb[b] && reg_offset_t'(addr[3:2]) == REG_SCRATCH) begin
            model_scratch[b*8 +: 8] = data[b*8 +: 8];
         end
      end
   endfunction

   // Initial RAM contents mixed from every address bit
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h2E67_5A5A;
   endfunction

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   // Waits until ready is seen high before a rising edge
   task automatic wait_ready(input string what, output bit ok);
      int waited;
      waited = 0;
      @(negedge clk);
      while (ready !== 1'b1 && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      ok = (ready === 1'b1);
      if (!ok) begin
         timed_out = 1'b1;
         $display("Timeout: %s was not accepted within %0d cycles", what, TIMEOUT);
      end
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      bit ok;
      if (!timed_out) begin
         avalid  = 1'b1;
         address = addr;
         wdata   = data;
         wstrb   = strb;
         wait_ready("write request", ok);
         if (ok) begin
            model_write(addr, data, strb);
         end
         @(posedge clk);
         #(DRV_DELAY);
         avalid = 1'b0;
         wstrb  = '0;
      end
   endtask

   task automatic bus_read(input logic [31:0] addr);
      bit ok;
      int waited;
      if (!timed_out) begin
         avalid  = 1'b1;
         address = addr;
         wstrb   = '0;
         wait_ready("read request", ok);
         @(posedge clk);
         // Expectation is queued on the accepting edge
         if (ok) begin
            exp_q.push_back(expected_read(addr));
            capture_q.push_back(is_count(addr));
         end
         #(DRV_DELAY);
         avalid = 1'b0;
         waited = 0;
         @(negedge clk);
         while (ok && rvalid !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
         end
         if (ok && rvalid !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout: no read response within %0d cycles", TIMEOUT);
         end
         @(posedge clk);
         #(DRV_DELAY);
      end
   endtask

   task automatic report_test(input string name, input int err_mark);
      if (errors == err_mark && !timed_out) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_mark);
      end
   endtask

   // Compare every response against the oldest expectation
   always @(negedge clk) begin
      if (rvalid === 1'b1) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t ns: rvalid with no read outstanding", $time);
         end else begin
            mon_exp = exp_q.pop_front();
            if (capture_q.pop_front()) begin
               count_seen.push_back(rdata);
            end else begin
               check_equal(rdata, mon_exp, "read data");
            end
         end
      end
   end

   initial begin
      int          err_mark;
      int          rst_wait;
      logic [31:0] addr;
      logic [3:0]  strb;

      void'($urandom(32'h2e67));
      avalid        = 1'b0;
      address       = '0;
      wdata         = '0;
      wstrb         = '0;
      errors        = 0;
      checks        = 0;
      timed_out     = 1'b0;
      model_scratch = '0;
      rst_wait      = 0;
      while (arst_n !== 1'b1 && rst_wait < TIMEOUT) begin
         @(posedge clk);
         rst_wait++;
      end
      if (arst_n !== 1'b1) begin
         timed_out = 1'b1;
         $display("Timeout: reset was not released within %0d cycles", TIMEOUT);
      end
      @(posedge clk);
      #(DRV_DELAY);

      err_mark = errors;
      repeat (3) begin
         @(negedge clk);
         check_equal({31'b0, rvalid}, '0, "rvalid after reset");
      end
      @(posedge clk);
      #(DRV_DELAY);
      bus_read(REG_BASE);
      bus_read(REG_BASE | 32'h4);
      report_test("reset values", err_mark);

      err_mark = errors;
      for (int i = 0; i < `BUS_RAM_WORDS; i++) begin
         bus_write(i << 2, fill_word(i << 2), 4'hF);
      end
      for (int i = 0; i < 30; i++) begin
         addr = ($urandom % `BUS_RAM_WORDS) << 2;
         strb = (i % 3 == 0) ? 4'hF : 4'(($urandom % 15) + 1);
         bus_write(addr, $urandom, strb);
         bus_read(addr);
      end
      report_test("ram write and read", err_mark);

      err_mark = errors;
      bus_write(REG_BASE, 32'h1122_3344, 4'hF);
      bus_read(REG_BASE);
      // Aliased scratch address with high bits set
      bus_write(REG_BASE | 32'h8000_0000, 32'hAABB_CCDD, 4'b0101);
      bus_read(REG_BASE);
      bus_write(REG_BASE | 32'h4, 32'hDEAD_BEEF, 4'hF);
      bus_read(REG_BASE | 32'h4);
      bus_write(REG_BASE | 32'h8, 32'h0, 4'hF);
      bus_read(REG_BASE | 32'h4);
      bus_read(REG_BASE | 32'hC);
      report_test("register writes", err_mark);

      err_mark = errors;
      for (int i = 0; i < 200; i++) begin
         addr = $urandom;
         addr[`BUS_SEL_BIT] = i[0];
         strb = 4'(($urandom % 15) + 1);
         if ($urandom % 2 == 0) begin
            bus_read(addr);
         end else begin
            bus_write(addr, $urandom, strb);
         end
      end
      check_equal(32'(exp_q.size()), '0, "responses still owed");
      report_test("interleaved traffic", err_mark);

      err_mark = errors;
      count_seen.delete();
      bus_read(REG_BASE | 32'h8);
      bus_read(REG_BASE | 32'h8);
      if (count_seen.size() == 2) begin
         check_equal({31'b0, count_seen[1] > count_seen[0]}, 32'h1, "counter increasing");
      end else begin
         errors++;
         $display("Error: expected two counter responses, saw %0d", count_seen.size());
      end
      report_test("counter", err_mark);

      repeat (2) @(posedge clk);
      $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 5
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release reset away from the clock edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2;
      arst_n_o = 1'b1;
   end

endmodule
